//--- design/keypad_params.svh
// Keypad display timing constants for row scan, debounce and digit multiplex
`ifndef KEYPAD_PARAMS_SVH
`define KEYPAD_PARAMS_SVH

// ==============================
// Row scanner
// ==============================
// Cycles each keypad row stays driven
`define KP_SCAN_TICKS 8

// ==============================
// Debouncer
// ==============================
// Consecutive stable cycles to confirm a press or a release
`define KP_DEBOUNCE_CYCLES 16

// ==============================
// Display
// ==============================
// Cycles each digit stays lit
`define KP_MUX_TICKS 4

`endif

//--- design/keypad_pkg.sv
// Shared key code and FSM state types for the keypad display
package keypad_pkg;

    // One hex key or digit value
    typedef logic [3:0] hex_digit_t;

    // Debouncer FSM
    typedef enum logic [1:0] {
        DEB_IDLE,     // Waiting for a key
        DEB_CONFIRM,  // Counting stable cycles
        DEB_HELD,     // Key registered and still down
        DEB_RELEASE   // Counting clean release cycles
    } deb_state_t;

    // Active display side
    typedef enum logic {
        SIDE_LEFT,    // select0 lit
        SIDE_RIGHT    // select1 lit
    } disp_side_t;

endpackage

//--- design/keypad_scanner.sv
// Keypad row scanner with two-stage column synchronizer and key detection
`timescale 1ns/10ps
`include "keypad_params.svh"

module keypad_scanner (
    input  logic       clk,
    input  logic       rst,           // Sync, active high
    input  logic [3:0] keypad_cols,   // Raw columns from the keypad
    input  logic       scan_stop,     // Hold the current row
    output logic [3:0] keypad_rows,   // One-hot row drive
    output logic [3:0] row_idx,       // Row matching col_sync
    output logic [3:0] col_sync,      // Columns after two flops
    output logic       key_detected   // Settled nonzero column
);

    // ==============================
    // Local constants and signals
    // ==============================
    localparam int unsigned DWELL_W    = $clog2(`KP_SCAN_TICKS);
    localparam int unsigned DWELL_LAST = `KP_SCAN_TICKS - 1;
    localparam int unsigned SETTLE     = 2;  // Synchronizer depth

    logic [DWELL_W-1:0] dwell_cnt;     // Cycles spent on this row
    logic [3:0]         col_meta;      // First sync stage
    logic [3:0]         row_d1;        // Row delayed one cycle
    logic               dwell_settled; // Sync pipe holds this row

    // ==============================
    // Row drive
    // ==============================
    // Rotate one-hot row every KP_SCAN_TICKS cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            dwell_cnt   <= '0;
            keypad_rows <= 4'b0001;        // Start on row 0
        end else if (!scan_stop) begin     // Frozen while a key is handled
            if (dwell_cnt == DWELL_W'(DWELL_LAST)) begin
                dwell_cnt   <= '0;
                keypad_rows <= {keypad_rows[2:0], keypad_rows[3]};  // Next row, wraps
            end else begin
                dwell_cnt <= dwell_cnt + 1'b1;
            end
        end
    end

    // ==============================
    // Column synchronizer
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            col_meta <= '0;
            col_sync <= '0;
            row_d1   <= 4'b0001;
            row_idx  <= 4'b0001;
        end else begin
            col_meta <= keypad_cols;       // May go metastable
            col_sync <= col_meta;
            // Row copy follows the same two-cycle lag
            row_d1   <= keypad_rows;
            row_idx  <= row_d1;
        end
    end

    // Columns for a new row reach col_sync two cycles into the dwell
    assign dwell_settled = (dwell_cnt >= DWELL_W'(SETTLE));

    // Key seen on the current row
    assign key_detected = dwell_settled && (col_sync != 4'b0000);

endmodule

//--- design/keypad_decoder.sv
// Keypad decoder turning one-hot row and column into a hex key code
`timescale 1ns/10ps

module keypad_decoder (
    input  logic [3:0]             row_idx,     // One-hot row
    input  logic [3:0]             col_sync,    // Synchronized columns
    output keypad_pkg::hex_digit_t key_code,    // 0 when invalid
    output logic                   code_valid   // Both inputs one-hot
);

    import keypad_pkg::*;

    logic [1:0] row_num;
    logic [1:0] col_num;
    logic       row_ok;
    logic       col_ok;
    hex_digit_t lut_code;

    // Returns {one_hot, index}
    function automatic logic [2:0] onehot_decode(input logic [3:0] v);
        case (v)
            4'b0001: return 3'b100;
            4'b0010: return 3'b101;
            4'b0100: return 3'b110;
            4'b1000: return 3'b111;
            default: return 3'b000;  // None or several lines
        endcase
    endfunction

    assign {row_ok, row_num} = onehot_decode(row_idx);
    assign {col_ok, col_num} = onehot_decode(col_sync);

    // ==============================
    // Key layout
    // ==============================
    always_comb begin
        case ({row_num, col_num})
            4'd0:    lut_code = 4'h1;  // Row 0
            4'd1:    lut_code = 4'h2;
            4'd2:    lut_code = 4'h3;
            4'd3:    lut_code = 4'hA;
            4'd4:    lut_code = 4'h4;  // Row 1
            4'd5:    lut_code = 4'h5;
            4'd6:    lut_code = 4'h6;
            4'd7:    lut_code = 4'hB;
            4'd8:    lut_code = 4'h7;  // Row 2
            4'd9:    lut_code = 4'h8;
            4'd10:   lut_code = 4'h9;
            4'd11:   lut_code = 4'hC;
            4'd12:   lut_code = 4'hE;  // Row 3
            4'd13:   lut_code = 4'h0;
            4'd14:   lut_code = 4'hF;
            default: lut_code = 4'hD;
        endcase
    end

    // Multi-column or empty reads are rejected
    assign code_valid = row_ok && col_ok;
    assign key_code   = code_valid ? lut_code : 4'h0;

endmodule

//--- design/keypad_debouncer.sv
// Keypad debouncer confirming a press, registering it once and waiting for release
`timescale 1ns/10ps
`include "keypad_params.svh"

module keypad_debouncer (
    input  logic                   clk,
    input  logic                   rst,            // Sync, active high
    input  logic                   key_detected,   // From scanner
    input  keypad_pkg::hex_digit_t key_code,       // From decoder
    input  logic                   code_valid,
    input  logic [3:0]             col_sync,       // Synchronized columns
    output logic                   scan_stop,      // Freeze row scan
    output logic                   key_valid,      // One-cycle pulse
    output keypad_pkg::hex_digit_t debounced_key   // Last accepted key
);

    import keypad_pkg::*;

    // ==============================
    // Local constants and signals
    // ==============================
    localparam int unsigned STAB_W    = $clog2(`KP_DEBOUNCE_CYCLES);
    localparam int unsigned STAB_LAST = `KP_DEBOUNCE_CYCLES - 1;

    deb_state_t        state;
    logic [STAB_W-1:0] stab_cnt;     // Stable cycle count
    logic [3:0]        col_latch;    // Column pattern at first sight
    hex_digit_t        code_latch;   // Candidate key
    logic              stab_done;
    logic              press_seen;   // Candidate in idle
    logic              col_same;     // Columns unchanged and single
    logic              confirm_hit;  // Press accepted this cycle

    assign stab_done   = (stab_cnt == STAB_W'(STAB_LAST));
    assign press_seen  = (state == DEB_IDLE) && key_detected && code_valid;
    assign col_same    = code_valid && (col_sync == col_latch);
    assign confirm_hit = (state == DEB_CONFIRM) && col_same && stab_done;

    // Row stays frozen for the whole press
    assign scan_stop = (state != DEB_IDLE);

    // ==============================
    // Press and release FSM
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= DEB_IDLE;
            stab_cnt  <= '0;
            key_valid <= 1'b0;
        end else begin
            key_valid <= 1'b0;  // Pulse default
            case (state)
                DEB_IDLE: begin
                    stab_cnt <= '0;
                    if (press_seen)
                        state <= DEB_CONFIRM;
                end
                DEB_CONFIRM: begin
                    if (!col_same) begin
                        state <= DEB_IDLE;          // Bounce or second column
                    end else if (stab_done) begin
                        key_valid <= 1'b1;          // Single registration
                        state     <= DEB_HELD;
                    end else begin
                        stab_cnt <= stab_cnt + 1'b1;
                    end
                end
                DEB_HELD: begin
                    stab_cnt <= '0;
                    if (col_sync == 4'b0000)
                        state <= DEB_RELEASE;
                end
                DEB_RELEASE: begin
                    if (col_sync != 4'b0000) begin
                        state <= DEB_HELD;          // Release bounce, no new pulse
                    end else if (stab_done) begin
                        state <= DEB_IDLE;          // Clean release
                    end else begin
                        stab_cnt <= stab_cnt + 1'b1;
                    end
                end
                default: state <= DEB_IDLE;
            endcase
        end
    end

    // ==============================
    // Key payload
    // ==============================
    always_ff @(posedge clk) begin
        if (press_seen) begin
            col_latch  <= col_sync;
            code_latch <= key_code;
        end
        if (confirm_hit)
            debounced_key <= code_latch;  // Steady from the pulse on
    end

endmodule

//--- design/digit_display.sv
// Two-digit key history with time-multiplexed active-low seven-segment output
`timescale 1ns/10ps
`include "keypad_params.svh"

module digit_display (
    input  logic                   clk,
    input  logic                   rst,            // Sync, active high
    input  logic                   key_valid,      // New key pulse
    input  keypad_pkg::hex_digit_t debounced_key,
    output logic [6:0]             seg,            // Active low, bit 0 is a
    output logic                   select0,        // Left digit enable
    output logic                   select1         // Right digit enable
);

    import keypad_pkg::*;

    // ==============================
    // Local constants and signals
    // ==============================
    localparam int unsigned MUX_W    = $clog2(`KP_MUX_TICKS);
    localparam int unsigned MUX_LAST = `KP_MUX_TICKS - 1;

    hex_digit_t       digit_left;   // Older key
    hex_digit_t       digit_right;  // Newest key
    hex_digit_t       shown_digit;
    logic [MUX_W-1:0] mux_cnt;      // Cycles on current side
    disp_side_t       side;

    // ==============================
    // Digit history
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            digit_left  <= 4'h0;
            digit_right <= 4'h0;
        end else if (key_valid) begin
            digit_left  <= digit_right;    // Shift left
            digit_right <= debounced_key;
        end
    end

    // ==============================
    // Multiplex timing
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            mux_cnt <= '0;
            side    <= SIDE_LEFT;          // Left lit first
        end else if (mux_cnt == MUX_W'(MUX_LAST)) begin
            mux_cnt <= '0;
            side    <= (side == SIDE_LEFT) ? SIDE_RIGHT : SIDE_LEFT;
        end else begin
            mux_cnt <= mux_cnt + 1'b1;
        end
    end

    // Exactly one enable at a time
    assign select0 = (side == SIDE_LEFT);
    assign select1 = (side == SIDE_RIGHT);

    assign shown_digit = (side == SIDE_LEFT) ? digit_left : digit_right;

    // Segment table
    // Bits are {g,f,e,d,c,b,a}, low lights a segment
    always_comb begin
        case (shown_digit)
            4'h0:    seg = 7'b1000000;
            4'h1:    seg = 7'b1111001;
            4'h2:    seg = 7'b0100100;
            4'h3:    seg = 7'b0110000;
            4'h4:    seg = 7'b0011001;
            4'h5:    seg = 7'b0010010;
            4'h6:    seg = 7'b0000010;
            4'h7:    seg = 7'b1111000;
            4'h8:    seg = 7'b0000000;
            4'h9:    seg = 7'b0010000;
            4'hA:    seg = 7'b0001000;
            4'hB:    seg = 7'b0000011;  // Lower case b
            4'hC:    seg = 7'b1000110;
            4'hD:    seg = 7'b0100001;  // Lower case d
            4'hE:    seg = 7'b0000110;
            default: seg = 7'b0001110;  // F
        endcase
    end

endmodule

//--- design/keypad_display_top.sv
// Keypad display top joining scanner, decoder, debouncer and two-digit display
`timescale 1ns/10ps

module keypad_display_top (
    input  logic       clk,
    input  logic       rst,           // Sync, active high
    input  logic [3:0] keypad_cols,   // Column inputs from the keypad
    output logic [3:0] keypad_rows,   // One-hot row drive
    output logic [6:0] seg,           // Active-low segments
    output logic       select0,       // Left digit enable
    output logic       select1        // Right digit enable
);

    import keypad_pkg::*;

    // ==============================
    // Internal signals
    // ==============================
    logic [3:0] row_idx;        // Scanner row, aligned with col_sync
    logic [3:0] col_sync;
    logic       key_detected;
    hex_digit_t key_code;       // Decoder output
    logic       code_valid;
    logic       scan_stop;      // Debouncer holds the row
    logic       key_valid;
    hex_digit_t debounced_key;

    // ==============================
    // Scan and decode
    // ==============================
    keypad_scanner u_scanner (
        .clk          (clk),
        .rst          (rst),
        .keypad_cols  (keypad_cols),
        .scan_stop    (scan_stop),
        .keypad_rows  (keypad_rows),
        .row_idx      (row_idx),
        .col_sync     (col_sync),
        .key_detected (key_detected)
    );

    keypad_decoder u_decoder (
        .row_idx    (row_idx),
        .col_sync   (col_sync),
        .key_code   (key_code),
        .code_valid (code_valid)
    );

    // ==============================
    // Debounce and display
    // ==============================
    keypad_debouncer u_debouncer (
        .clk           (clk),
        .rst           (rst),
        .key_detected  (key_detected),
        .key_code      (key_code),
        .code_valid    (code_valid),
        .col_sync      (col_sync),
        .scan_stop     (scan_stop),
        .key_valid     (key_valid),
        .debounced_key (debounced_key)
    );

    digit_display u_display (
        .clk           (clk),
        .rst           (rst),
        .key_valid     (key_valid),
        .debounced_key (debounced_key),
        .seg           (seg),
        .select0       (select0),
        .select1       (select1)
    );

endmodule

//--- tests/tb_keypad_display.sv
// Keypad display testbench with a keypad matrix model and self-checking assertions
`timescale 1ns/10ps
`include "keypad_params.svh"

module tb_keypad_display;

    import keypad_pkg::*;

    // ==============================
    // Constants and signals
    // ==============================
    localparam int HOLD_CYCLES    = 100;    // Normal press length
    localparam int RELEASE_CYCLES = 40;     // Quiet gap after a release
    localparam int TIMEOUT_CYCLES = 20000;  // About 16 presses of 160 cycles with wide margin

    logic        clk;
    logic        rst;
    logic [3:0]  keypad_cols;
    logic [3:0]  keypad_rows;
    logic [6:0]  seg;
    logic        select0;
    logic        select1;
    logic [15:0] pressed;        // One bit per key, index row*4+col
    hex_digit_t  exp_left;       // Expected digit history
    hex_digit_t  exp_right;
    logic        exp_sel0;       // Expected left enable
    int          mux_ticks;      // Cycles on the expected side
    logic        seg_check_en;   // Off while the display may be updating
    integer      seed = 32'h705a_41ed;
    int          err_count;
    int          err_mark;       // Errors before the current test
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          cycle_cnt;

    // Keypad layout, index row*4+col
    hex_digit_t key_layout [16] = '{4'h1, 4'h2, 4'h3, 4'hA, 4'h4, 4'h5, 4'h6, 4'hB,
                                    4'h7, 4'h8, 4'h9, 4'hC, 4'hE, 4'h0, 4'hF, 4'hD};
    // Active-low segments {g..a} for digits 0 to F
    logic [6:0] seg_table [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                                   7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

    keypad_display_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // ==============================
    // Keypad matrix model
    // ==============================
    // A pressed key ties its row to its column
    always_comb begin
        keypad_cols = 4'b0000;
        for (int r = 0; r < 4; r++)
            for (int c = 0; c < 4; c++)
                if (keypad_rows[r] && pressed[r*4+c])
                    keypad_cols[c] = 1'b1;
    end

    // ==============================
    // Reference multiplex phase
    // ==============================
    // Left side first after reset, then a swap every KP_MUX_TICKS cycles
    always @(posedge clk) begin
        if (rst) begin
            mux_ticks <= 0;
            exp_sel0  <= 1'b1;
        end else if (mux_ticks == `KP_MUX_TICKS - 1) begin
            mux_ticks <= 0;
            exp_sel0  <= ~exp_sel0;
        end else begin
            mux_ticks <= mux_ticks + 1;
        end
    end

    // ==============================
    // Assertions
    // ==============================
    rows_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(keypad_rows))
        else begin
            err_count++;
            $display("[FAIL] t=%0t keypad_rows expected one-hot, got %b", $time,
                     $sampled(keypad_rows));
        end

    // One enable high, swapping on the multiplex period
    select_phase: assert property (@(posedge clk) disable iff (rst)
            select0 == exp_sel0 && select1 == !exp_sel0)
        else begin
            err_count++;
            $display("[FAIL] t=%0t select0,select1 expected %b%b, got %b%b", $time,
                     $sampled(exp_sel0), !$sampled(exp_sel0),
                     $sampled(select0), $sampled(select1));
        end

    // Shown digit follows the side that should be lit
    seg_matches: assert property (@(posedge clk) disable iff (rst || !seg_check_en)
            seg == seg_table[exp_sel0 ? exp_left : exp_right])
        else begin
            err_count++;
            $display("[FAIL] t=%0t seg expected %b, got %b", $time,
                     seg_table[$sampled(exp_sel0) ? exp_left : exp_right], $sampled(seg));
        end

    // ==============================
    // Helper tasks
    // ==============================
    task automatic compare_value(input string name, input logic [6:0] expected,
                                 input logic [6:0] actual);
        checks++;
        assert (actual == expected) else begin
            err_count++;
            $display("[FAIL] t=%0t %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    endtask

    // Press keys, then update the expected history once the press has settled
    task automatic hold_keys(input logic [15:0] mask, input int cycles,
                             input bit accepted, input hex_digit_t digit);
        seg_check_en = 1'b0;
        pressed      = mask;
        repeat (cycles) @(negedge clk);
        if (accepted) begin
            exp_left  = exp_right;  // Shift rule
            exp_right = digit;
        end
        seg_check_en = 1'b1;
    endtask

    // Release with optional contact bounce, each toggle shorter than the debounce
    task automatic release_keys(input logic [15:0] mask, input int bounces);
        int gap;
        for (int b = 0; b < bounces; b++) begin
            pressed = '0;
            gap = 2 + ($unsigned($random(seed)) % 9);
            repeat (gap) @(negedge clk);
            pressed = mask;
            gap = 2 + ($unsigned($random(seed)) % 9);
            repeat (gap) @(negedge clk);
        end
        pressed = '0;
        repeat (RELEASE_CYCLES) @(negedge clk);
    endtask

    // Key whose digit differs from the newest one, so a double entry shows up
    task automatic pick_new_key(output int k);
        do begin
            k = $unsigned($random(seed)) % 16;
        end while (key_layout[k] == exp_right);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (err_count == err_mark) begin
            $display("Test %0d %s: PASS", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAIL, %0d errors", tests_run, name, err_count - err_mark);
        end
        err_mark = err_count;
    endtask

    // Watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        int         order [16];
        int         i;
        int         j;
        int         k;
        int         tmp;
        logic [3:0] rows_seen;

        pressed      = '0;
        exp_left     = 4'h0;
        exp_right    = 4'h0;
        seg_check_en = 1'b0;
        err_count    = 0;
        err_mark     = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        apply_reset();

        // Reset values, then free-running scan with 0 on both sides
        compare_value("keypad_rows", 7'h01, {3'b000, keypad_rows});
        compare_value("select0", 7'h01, {6'b000000, select0});
        compare_value("seg", seg_table[0], seg);
        seg_check_en = 1'b1;
        rows_seen    = 4'b0000;
        repeat (4 * `KP_SCAN_TICKS) begin
            @(negedge clk);
            rows_seen = rows_seen | keypad_rows;
        end
        compare_value("keypad_rows seen", 7'h0F, {3'b000, rows_seen});
        report_test("reset and idle scan");

        // All 16 keys in shuffled order
        for (i = 0; i < 16; i++)
            order[i] = i;
        for (i = 15; i > 0; i--) begin
            j        = $unsigned($random(seed)) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (i = 0; i < 16; i++) begin
            hold_keys(16'h0001 << order[i], HOLD_CYCLES, 1'b1, key_layout[order[i]]);
            release_keys(16'h0001 << order[i], 0);
        end
        report_test("all keys shift in");

        pick_new_key(k);
        hold_keys(16'h0001 << k, 400, 1'b1, key_layout[k]);
        release_keys(16'h0001 << k, 0);
        report_test("long hold registers once");

        // Glitches below KP_DEBOUNCE_CYCLES minus 4
        for (i = 0; i < 3; i++) begin
            k = $unsigned($random(seed)) % 16;
            hold_keys(16'h0001 << k, 2 + ($unsigned($random(seed)) % 10), 1'b0, 4'h0);
            release_keys(16'h0001 << k, 0);
        end
        pick_new_key(k);
        hold_keys(16'h0001 << k, HOLD_CYCLES, 1'b1, key_layout[k]);
        release_keys(16'h0001 << k, 3);
        report_test("short press and release bounce");

        // Two adjacent columns of one row
        k = ($unsigned($random(seed)) % 4) * 4 + ($unsigned($random(seed)) % 2) * 2;
        hold_keys(16'h0003 << k, HOLD_CYCLES, 1'b0, 4'h0);
        release_keys(16'h0003 << k, 0);
        report_test("multi-column read ignored");

        exp_left  = 4'h0;
        exp_right = 4'h0;
        apply_reset();
        compare_value("keypad_rows", 7'h01, {3'b000, keypad_rows});
        compare_value("select0", 7'h01, {6'b000000, select0});
        compare_value("seg", seg_table[0], seg);
        repeat (2 * `KP_MUX_TICKS) @(negedge clk);
        report_test("mid-run reset");

        $display("Summary: %0d tests, %0d failed, %0d point checks, %0d errors",
                 tests_run, tests_failed, checks, err_count);
        if (err_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+design
design/keypad_pkg.sv
design/keypad_scanner.sv
design/keypad_decoder.sv
design/keypad_debouncer.sv
design/digit_display.sv
design/keypad_display_top.sv
tests/tb_keypad_display.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_keypad_display
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(wildcard design/*.sv design/*.svh tests/*.sv)
PASS_MSG  := Verification passed

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
